//--- sources.f
logic/axi_wr_pkg.sv
logic/pcie_tlp_pkg.sv
logic/ob_fifo.sv
logic/ob_write_buffer.sv
logic/ob_cmd_splitter.sv
logic/ob_tlp_builder.sv
logic/ob_write_top.sv
testbench/tb_clock.sv
testbench/tb_ob_write.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_ob_write -f sources.f -o sim_ob_write

./obj_dir/sim_ob_write | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- testbench/tb_ob_write.sv
module tb_ob_write
    import axi_wr_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MOT         = 16;
    localparam int          MAX_PAYLOAD = 4;
    localparam logic [15:0] REQ_ID      = 16'h0100;
    localparam int          TIMEOUT     = 4000;

    logic        clk;
    logic        rst;
    logic        aw_ready;
    logic        aw_valid;
    logic [31:0] aw_addr;
    logic [3:0]  aw_len;
    logic        w_ready;
    logic        w_valid;
    logic        w_last;
    logic [3:0]  w_strb;
    logic [31:0] w_data;
    logic        b_ready;
    logic        b_valid;
    axi_resp_e   b_resp;
    logic        tx_valid;
    logic        tx_ready;
    logic [31:0] tx_data;
    logic        tx_sop;
    logic        tx_eop;

    integer seed = 32'ha5905f99;

    // Expected tx dwords, in order
    logic [31:0] exp_data [$];
    logic        exp_sop  [$];
    logic        exp_eop  [$];
    logic        exp_end  [$];
    logic [31:0] cur_data [$];
    logic [3:0]  cur_strb [$];

    int errors          = 0;
    int tests_passed    = 0;
    int tests_failed    = 0;
    int bursts_accepted = 0;
    int bursts_sent     = 0;
    int resp_count      = 0;
    int tx_mode         = 1;  // 1 always ready, 2 random
    int b_mode          = 1;  // 0 held low, 1 always ready, 2 random

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    ob_write_top #(
        .MOT         (MOT),
        .MAX_PAYLOAD (MAX_PAYLOAD),
        .REQ_ID      (REQ_ID)
    ) i_dut (.*);

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [3:0] random_strobe();
        logic [3:0] s;
        s = 4'($random(seed));
        if (s == 4'h0) begin
            s = 4'h1;
        end
        return s;
    endfunction

    function automatic void push_dword(input logic [31:0] d, input logic sop,
                                       input logic eop, input logic burst_end);
        exp_data.push_back(d);
        exp_sop.push_back(sop);
        exp_eop.push_back(eop);
        exp_end.push_back(burst_end);
    endfunction

    // Partial strobes only on the first and last beat
    task automatic make_burst(input int len);
        cur_data = {};
        cur_strb = {};
        for (int i = 0; i <= len; i++) begin
            cur_data.push_back($random(seed));
            cur_strb.push_back((i == 0 || i == len) ? random_strobe() : 4'hf);
        end
    endtask

    // Reference split: cut at aligned payload boundaries, three-dword MWr32 header
    task automatic model_burst(input logic [29:0] dw_addr, input int len);
        logic [29:0] addr;
        logic [3:0]  last_be;
        int          left;
        int          idx;
        int          seg;
        addr = dw_addr;
        left = len + 1;
        idx  = 0;
        while (left > 0) begin
            seg = MAX_PAYLOAD - int'(addr % 30'(MAX_PAYLOAD));
            if (left < seg) begin
                seg = left;
            end
            last_be = (seg == 1) ? 4'h0 : cur_strb[idx + seg - 1];
            push_dword({3'b010, 5'b00000, 14'd0, 10'(seg)}, 1'b1, 1'b0, 1'b0);
            push_dword({REQ_ID, 8'h00, last_be, cur_strb[idx]}, 1'b0, 1'b0, 1'b0);
            push_dword({addr, 2'b00}, 1'b0, 1'b0, 1'b0);
            for (int i = 0; i < seg; i++) begin
                push_dword(cur_data[idx + i], 1'b0, i == seg - 1, left == seg && i == seg - 1);
            end
            addr = addr + 30'(seg);
            idx  = idx + seg;
            left = left - seg;
        end
    endtask

    // Driver tasks start and return at a falling edge
    task automatic send_aw(input logic [29:0] dw_addr, input int len, input int limit,
                           output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        aw_valid = 1'b1;
        aw_addr  = {dw_addr, 2'b00};
        aw_len   = 4'(len);
        while (!ok && n < limit) begin
            @(posedge clk);
            ok = aw_ready;
            n++;
        end
        @(negedge clk);
        aw_valid = 1'b0;
    endtask

    task automatic send_beat(input logic [31:0] data, input logic [3:0] strb, input logic last);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        w_valid = 1'b1;
        w_data  = data;
        w_strb  = strb;
        w_last  = last;
        while (!done && n < TIMEOUT) begin
            @(posedge clk);
            done = w_ready;
            n++;
        end
        if (!done) begin
            report_failure("w_ready never rose for a write beat");
        end
        @(negedge clk);
    endtask

    task automatic run_burst(input logic [29:0] dw_addr, input int len, input int limit,
                             output bit ok);
        make_burst(len);
        send_aw(dw_addr, len, limit, ok);
        if (ok) begin
            model_burst(dw_addr, len);
            bursts_accepted++;
            for (int i = 0; i <= len; i++) begin
                send_beat(cur_data[i], cur_strb[i], i == len);
            end
            w_valid = 1'b0;
        end
    endtask

    task automatic random_bursts(input int count, input int max_len);
        bit ok;
        int len;
        repeat (count) begin
            len = int'($random(seed) & 32'hf) % (max_len + 1);
            run_burst(30'($random(seed)), len, TIMEOUT, ok);
            if (!ok) begin
                report_failure("aw_ready never rose for a burst");
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((exp_data.size() != 0 || resp_count != bursts_accepted) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_data.size() != 0 || resp_count != bursts_accepted) begin
            report_failure("tx stream or write responses stalled before the test ended");
        end
        @(negedge clk);
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - err_before);
        end
    endtask

    // Ready signals change on the falling edge
    always @(negedge clk) begin
        tx_ready = (tx_mode == 2) ? 1'($random(seed)) : 1'b1;
        b_ready  = (b_mode == 2) ? 1'($random(seed)) : (b_mode == 1);
    end

    // Transfers are taken at the rising edge
    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            if (exp_data.size() == 0) begin
                report_failure("tx dword appeared with no TLP expected");
            end else begin
                compare_value("tx_data", exp_data.pop_front(), tx_data);
                compare_value("tx_sop", 32'(exp_sop.pop_front()), 32'(tx_sop));
                compare_value("tx_eop", 32'(exp_eop.pop_front()), 32'(tx_eop));
                if (exp_end.pop_front()) begin
                    bursts_sent++;
                end
            end
        end
        if (!rst && b_valid && b_ready) begin
            compare_value("b_resp", 32'(OKAY), 32'(b_resp));
            if (resp_count >= bursts_sent) begin
                report_failure("write response arrived before the last dword of its burst");
            end
            resp_count++;
        end
    end

    initial begin
        int start;
        int n;
        int accepted;
        bit ok;
        aw_valid = 1'b0;
        aw_addr  = '0;
        aw_len   = '0;
        w_valid  = 1'b0;
        w_last   = 1'b0;
        w_strb   = '0;
        w_data   = '0;
        b_ready  = 1'b0;
        tx_ready = 1'b0;

        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            report_failure("reset was never released");
        end
        @(negedge clk);

        start = errors;
        random_bursts(12, 0);
        wait_idle();
        end_test("Test 1 single-beat writes", start);

        start = errors;
        random_bursts(30, 15);
        wait_idle();
        end_test("Test 2 bursts at random addresses", start);

        start = errors;
        tx_mode = 2;
        random_bursts(30, 15);
        wait_idle();
        end_test("Test 3 tx back-pressure", start);

        start = errors;
        b_mode = 2;
        random_bursts(30, 15);
        wait_idle();
        b_mode = 1;
        tx_mode = 1;
        end_test("Test 4 write responses", start);

        // Beat offered before its command
        start = errors;
        make_burst(0);
        w_valid = 1'b1;
        w_data  = cur_data[0];
        w_strb  = cur_strb[0];
        w_last  = 1'b1;
        repeat (8) begin
            @(posedge clk);
            compare_value("w_ready", 32'd0, 32'(w_ready));
        end
        @(negedge clk);
        send_aw(30'($random(seed)), 0, TIMEOUT, ok);
        if (!ok) begin
            report_failure("aw_ready never rose with data waiting");
        end else begin
            model_burst(30'(aw_addr >> 2), 0);
            bursts_accepted++;
            send_beat(cur_data[0], cur_strb[0], 1'b1);
        end
        w_valid = 1'b0;
        wait_idle();
        end_test("Test 5 data before command", start);

        start = errors;
        b_mode = 0;
        accepted = 0;
        ok = 1'b1;
        while (ok && accepted <= MOT) begin
            run_burst(30'($random(seed)), int'($random(seed) & 32'hf), 200, ok);
            if (ok) begin
                accepted++;
            end
        end
        compare_value("accepted bursts", 32'(MOT), 32'(accepted));
        b_mode = 1;
        wait_idle();
        run_burst(30'($random(seed)), int'($random(seed) & 32'hf), TIMEOUT, ok);
        if (!ok) begin
            report_failure("aw_ready did not recover after responses drained");
        end
        wait_idle();
        end_test("Test 6 outstanding limit", start);

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset spans the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- logic/ob_write_top.sv
module ob_write_top
    import axi_wr_pkg::*;
    import pcie_tlp_pkg::*;
#(
    parameter int          ADDR        = AXI_ADDR_W,
    parameter int          LEN         = AXI_LEN_W,
    parameter int          MOT         = 16,
    parameter int          BUFA        = LEN + 1,
    parameter int          MAX_PAYLOAD = 4,
    parameter logic [15:0] REQ_ID      = 16'h0100
) (
    input  logic            clk,
    input  logic            rst,
    output logic            aw_ready,
    input  logic            aw_valid,
    input  logic [ADDR-1:0] aw_addr,
    input  logic [LEN-1:0]  aw_len,
    output logic            w_ready,
    input  logic            w_valid,
    input  logic            w_last,
    input  logic [3:0]      w_strb,
    input  logic [31:0]     w_data,
    input  logic            b_ready,
    output logic            b_valid,
    output axi_resp_e       b_resp,
    output logic            tx_valid,
    input  logic            tx_ready,
    output logic [31:0]     tx_data,
    output logic            tx_sop,
    output logic            tx_eop
);

    // Buffer to splitter
    logic                 cmd_aw_ready;
    logic                 cmd_aw_valid;
    logic [ADDR-1:2]      cmd_aw_addr;
    logic [LEN-1:0]       cmd_aw_len;
    logic                 cmd_w_ready;
    logic                 cmd_w_valid;
    logic [3:0]           cmd_w_strb;

    // Splitter to builder
    logic                 hdr_valid;
    logic                 hdr_ready;
    logic [ADDR-1:2]      hdr_addr;
    logic [TLP_LEN_W-1:0] hdr_len;
    logic [TLP_BE_W-1:0]  hdr_first_be;
    logic [TLP_BE_W-1:0]  hdr_last_be;

    // Buffer to builder
    logic                 tlp_d_ready;
    logic                 tlp_d_valid;
    logic [31:0]          tlp_d_data;
    logic                 tlp_d_axi_last;
    logic                 tlp_d_axi_ack;

    ob_write_buffer #(
        .ADDR (ADDR),
        .LEN  (LEN),
        .MOT  (MOT),
        .BUFA (BUFA)
    ) i_write_buffer (.*);

    ob_cmd_splitter #(
        .ADDR        (ADDR),
        .LEN         (LEN),
        .MAX_PAYLOAD (MAX_PAYLOAD)
    ) i_cmd_splitter (.*);

    ob_tlp_builder #(
        .ADDR   (ADDR),
        .REQ_ID (REQ_ID)
    ) i_tlp_builder (.*);

endmodule

//--- logic/ob_tlp_builder.sv
module ob_tlp_builder
    import axi_wr_pkg::*;
    import pcie_tlp_pkg::*;
#(
    parameter int          ADDR   = AXI_ADDR_W,
    parameter logic [15:0] REQ_ID = 16'h0100
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hdr_valid,
    output logic                 hdr_ready,
    input  logic [ADDR-1:2]      hdr_addr,
    input  logic [TLP_LEN_W-1:0] hdr_len,
    input  logic [TLP_BE_W-1:0]  hdr_first_be,
    input  logic [TLP_BE_W-1:0]  hdr_last_be,
    output logic                 tlp_d_ready,
    input  logic                 tlp_d_valid,
    input  logic [31:0]          tlp_d_data,
    input  logic                 tlp_d_axi_last,
    output logic                 tlp_d_axi_ack,
    output logic                 tx_valid,
    input  logic                 tx_ready,
    output logic [31:0]          tx_data,
    output logic                 tx_sop,
    output logic                 tx_eop
);

    tlp_state_e           state;
    logic [TLP_LEN_W-1:0] data_left;
    logic                 tx_acc;
    logic                 last_dw;

    assign tx_acc  = tx_valid && tx_ready;
    assign last_dw = (state == DATA) && (data_left == TLP_LEN_W'(1));

    // Header is held by the splitter until the TLP is fully sent
    assign hdr_ready     = tx_acc && last_dw;
    assign tlp_d_ready   = (state == DATA) && tx_ready;
    assign tlp_d_axi_ack = tx_acc && (state == DATA) && tlp_d_axi_last;
    assign tx_sop        = (state == HDR0);
    assign tx_eop        = last_dw;

    always_comb begin
        case (state)
            HDR0: begin
                tx_valid = 1'b1;
                tx_data  = {MWR32, 14'd0, hdr_len};
            end
            HDR1: begin
                // Tag is always zero
                tx_valid = 1'b1;
                tx_data  = {REQ_ID, 8'h00, hdr_last_be, hdr_first_be};
            end
            HDR2: begin
                tx_valid = 1'b1;
                tx_data  = 32'({hdr_addr, 2'b00});
            end
            DATA: begin
                tx_valid = tlp_d_valid;
                tx_data  = tlp_d_data;
            end
            default: begin
                tx_valid = 1'b0;
                tx_data  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (hdr_valid) state <= HDR0;
                HDR0:    if (tx_ready) state <= HDR1;
                HDR1:    if (tx_ready) state <= HDR2;
                HDR2:    if (tx_ready) state <= DATA;
                DATA:    if (tx_acc && last_dw) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Payload dwords still to send
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            data_left <= hdr_len;
        end else if (state == DATA && tx_acc) begin
            data_left <= data_left - 1'b1;
        end
    end

    // Stalled beat must not change, including payload from the buffer
    assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready
        |=> tx_valid && $stable(tx_data) && $stable(tx_sop) && $stable(tx_eop));

endmodule

//--- logic/ob_cmd_splitter.sv
module ob_cmd_splitter
    import axi_wr_pkg::*;
    import pcie_tlp_pkg::*;
#(
    parameter int ADDR        = AXI_ADDR_W,
    parameter int LEN         = AXI_LEN_W,
    parameter int MAX_PAYLOAD = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 cmd_aw_ready,
    input  logic                 cmd_aw_valid,
    input  logic [ADDR-1:2]      cmd_aw_addr,
    input  logic [LEN-1:0]       cmd_aw_len,
    output logic                 cmd_w_ready,
    input  logic                 cmd_w_valid,
    input  logic [3:0]           cmd_w_strb,
    output logic                 hdr_valid,
    input  logic                 hdr_ready,
    output logic [ADDR-1:2]      hdr_addr,
    output logic [TLP_LEN_W-1:0] hdr_len,
    output logic [TLP_BE_W-1:0]  hdr_first_be,
    output logic [TLP_BE_W-1:0]  hdr_last_be
);

    localparam int CW = TLP_LEN_W + 1;
    localparam int AW = ADDR - 2;

    typedef enum logic [1:0] {
        S_CMD,
        S_CUT,
        S_STRB,
        S_HDR
    } split_state_e;

    split_state_e  state;
    logic [AW-1:0] cur_addr;
    logic [CW-1:0] beats_left;
    logic [CW-1:0] tlp_len;
    logic [CW-1:0] strb_left;
    logic [CW-1:0] to_bound;
    logic [CW-1:0] seg_len;
    logic          burst_first;
    logic          strb_acc;
    logic          strb_first;
    logic          strb_last;

    assign cmd_aw_ready = (state == S_CMD);
    assign cmd_w_ready  = (state == S_STRB);
    assign hdr_valid    = (state == S_HDR);
    assign hdr_addr     = cur_addr;
    assign hdr_len      = tlp_len[TLP_LEN_W-1:0];

    assign strb_acc   = cmd_w_valid && cmd_w_ready;
    assign strb_first = (strb_left == tlp_len);
    assign strb_last  = (strb_left == CW'(1));

    // Dwords left before the next aligned payload boundary
    assign to_bound = CW'(MAX_PAYLOAD) - CW'(cur_addr % MAX_PAYLOAD);
    assign seg_len  = (beats_left < to_bound) ? beats_left : to_bound;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_CMD;
        end else begin
            case (state)
                S_CMD:   if (cmd_aw_valid) state <= S_CUT;
                S_CUT:   state <= S_STRB;
                S_STRB:  if (strb_acc && strb_last) state <= S_HDR;
                S_HDR:   if (hdr_ready) state <= (beats_left == tlp_len) ? S_CMD : S_CUT;
                default: state <= S_CMD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_CMD: begin
                cur_addr    <= cmd_aw_addr;
                beats_left  <= CW'(cmd_aw_len) + CW'(1);
                burst_first <= 1'b1;
            end
            S_CUT: begin
                tlp_len   <= seg_len;
                strb_left <= seg_len;
            end
            S_STRB: begin
                if (strb_acc) begin
                    strb_left   <= strb_left - CW'(1);
                    burst_first <= 1'b0;
                    if (strb_first) begin
                        hdr_first_be <= cmd_w_strb;
                    end
                    // Single-dword TLPs carry a zero last_be
                    if (strb_last) begin
                        hdr_last_be <= (tlp_len == CW'(1)) ? '0 : cmd_w_strb;
                    end
                end
            end
            default: begin
                if (hdr_ready) begin
                    cur_addr   <= cur_addr + AW'(tlp_len);
                    beats_left <= beats_left - tlp_len;
                end
            end
        endcase
    end

    // Partial strobes are allowed only on the first and last beat of a burst
    assert property (@(posedge clk) disable iff (rst)
        strb_acc && !burst_first && !(strb_last && beats_left == tlp_len)
        |-> cmd_w_strb == 4'hf);

endmodule

//--- logic/ob_write_buffer.sv
module ob_write_buffer
    import axi_wr_pkg::*;
#(
    parameter int ADDR = AXI_ADDR_W,
    parameter int LEN  = AXI_LEN_W,
    parameter int MOT  = 16,
    parameter int BUFA = LEN + 1
) (
    input  logic            clk,
    input  logic            rst,
    output logic            aw_ready,
    input  logic            aw_valid,
    input  logic [ADDR-1:0] aw_addr,
    input  logic [LEN-1:0]  aw_len,
    output logic            w_ready,
    input  logic            w_valid,
    input  logic            w_last,
    input  logic [3:0]      w_strb,
    input  logic [31:0]     w_data,
    input  logic            b_ready,
    output logic            b_valid,
    output axi_resp_e       b_resp,
    input  logic            cmd_aw_ready,
    output logic            cmd_aw_valid,
    output logic [ADDR-1:2] cmd_aw_addr,
    output logic [LEN-1:0]  cmd_aw_len,
    input  logic            cmd_w_ready,
    output logic            cmd_w_valid,
    output logic [3:0]      cmd_w_strb,
    input  logic            tlp_d_ready,
    output logic            tlp_d_valid,
    output logic [31:0]     tlp_d_data,
    output logic            tlp_d_axi_last,
    input  logic            tlp_d_axi_ack
);

    localparam int MOTB = $clog2(MOT + 1);
    localparam int BW   = BUFA + 1;

    logic            aw_acc;
    logic            w_acc;
    logic            b_acc;
    logic            d_pop;
    logic            aw_almost_full;
    logic [MOTB-1:0] mot_cnt;
    logic [MOTB-1:0] next_mot_cnt;
    logic [BW-1:0]   buf_free;
    logic [BW-1:0]   next_buf_free;
    logic [MOTB-1:0] w_cnt;
    logic [MOTB-1:0] b_cnt;

    assign aw_acc = aw_ready && aw_valid;
    assign w_acc  = w_ready && w_valid;
    assign b_acc  = b_ready && b_valid;
    assign d_pop  = tlp_d_ready && tlp_d_valid;
    assign b_resp = OKAY;

    // Bursts between command and response
    always_comb begin
        next_mot_cnt = mot_cnt;
        if (aw_acc && !b_acc) begin
            next_mot_cnt = mot_cnt + 1'b1;
        end else if (!aw_acc && b_acc) begin
            next_mot_cnt = mot_cnt - 1'b1;
        end
    end

    // Whole burst reserved up front, freed dword by dword
    always_comb begin
        next_buf_free = buf_free;
        if (aw_acc) begin
            next_buf_free = next_buf_free - BW'(aw_len) - BW'(1);
        end
        if (d_pop) begin
            next_buf_free = next_buf_free + BW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mot_cnt  <= '0;
            buf_free <= BW'(2 ** BUFA);
            aw_ready <= 1'b0;
        end else begin
            mot_cnt  <= next_mot_cnt;
            buf_free <= next_buf_free;
            // Room for a max-size burst and a free command slot
            aw_ready <= (|next_buf_free[BUFA:LEN]) && (next_mot_cnt < MOTB'(MOT))
                        && !aw_almost_full;
        end
    end

    // Commands whose data is still due
    always_ff @(posedge clk) begin
        if (rst) begin
            w_cnt   <= '0;
            w_ready <= 1'b0;
        end else if (aw_acc && !(w_acc && w_last)) begin
            w_cnt   <= w_cnt + 1'b1;
            w_ready <= 1'b1;
        end else if (!aw_acc && w_acc && w_last) begin
            w_cnt   <= w_cnt - 1'b1;
            w_ready <= (w_cnt != MOTB'(1));
        end
    end

    // Responses owed after builder ack
    always_ff @(posedge clk) begin
        if (rst) begin
            b_cnt   <= '0;
            b_valid <= 1'b0;
        end else if (tlp_d_axi_ack && !b_acc) begin
            b_cnt   <= b_cnt + 1'b1;
            b_valid <= 1'b1;
        end else if (!tlp_d_axi_ack && b_acc) begin
            b_cnt   <= b_cnt - 1'b1;
            b_valid <= (b_cnt != MOTB'(1));
        end
    end

    ob_fifo #(
        .DATA        (ADDR - 2 + LEN),
        .ADDR        (2),
        .ALMOST_FULL (1)
    ) i_cmd_fifo (
        .clk            (clk),
        .rst            (rst),
        .wr_push        (aw_acc),
        .wr_data        ({aw_addr[ADDR-1:2], aw_len}),
        .wr_almost_full (aw_almost_full),
        .wr_full        (),
        .rd_ready       (cmd_aw_ready),
        .rd_valid       (cmd_aw_valid),
        .rd_data        ({cmd_aw_addr, cmd_aw_len})
    );

    // Strobes for the splitter
    ob_fifo #(
        .DATA        (4),
        .ADDR        (BUFA),
        .ALMOST_FULL (1)
    ) i_strb_fifo (
        .clk            (clk),
        .rst            (rst),
        .wr_push        (w_acc),
        .wr_data        (w_strb),
        .wr_almost_full (),
        .wr_full        (),
        .rd_ready       (cmd_w_ready),
        .rd_valid       (cmd_w_valid),
        .rd_data        (cmd_w_strb)
    );

    // Payload with burst-end marker
    ob_fifo #(
        .DATA        (33),
        .ADDR        (BUFA),
        .ALMOST_FULL (1)
    ) i_data_fifo (
        .clk            (clk),
        .rst            (rst),
        .wr_push        (w_acc),
        .wr_data        ({w_last, w_data}),
        .wr_almost_full (),
        .wr_full        (),
        .rd_ready       (tlp_d_ready),
        .rd_valid       (tlp_d_valid),
        .rd_data        ({tlp_d_axi_last, tlp_d_data})
    );

    assert property (@(posedge clk) disable iff (rst) mot_cnt <= MOTB'(MOT));

    // A response is only offered when the builder has acked its burst
    assert property (@(posedge clk) disable iff (rst) b_valid |-> (b_cnt != '0));

endmodule

//--- logic/ob_fifo.sv
module ob_fifo #(
    parameter int DATA        = 8,
    parameter int ADDR        = 4,
    parameter int ALMOST_FULL = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_push,
    input  logic [DATA-1:0] wr_data,
    output logic            wr_almost_full,
    output logic            wr_full,
    input  logic            rd_ready,
    output logic            rd_valid,
    output logic [DATA-1:0] rd_data
);

    localparam int DEPTH = 2 ** ADDR;
    localparam int CW    = ADDR + 1;

    logic [DATA-1:0] mem [DEPTH];
    logic [ADDR-1:0] wr_ptr;
    logic [ADDR-1:0] rd_ptr;
    logic [CW-1:0]   count;
    logic            rd_pop;

    assign rd_pop         = rd_ready && rd_valid;
    assign rd_valid       = (count != '0);
    assign wr_full        = (count == CW'(DEPTH));
    assign wr_almost_full = (count >= CW'(DEPTH - ALMOST_FULL));

    // Head entry always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_push, rd_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writer side must honour wr_full
    assert property (@(posedge clk) disable iff (rst) wr_push |-> !wr_full);

endmodule

//--- logic/pcie_tlp_pkg.sv
package pcie_tlp_pkg;

    // Fmt in bits 7:5, type in bits 4:0
    typedef enum logic [7:0] {
        MRD32 = 8'h00,
        MWR32 = 8'h40
    } tlp_fmt_type_e;

    // Transmit sequencing of one TLP
    typedef enum logic [2:0] {
        IDLE,
        HDR0,
        HDR1,
        HDR2,
        DATA
    } tlp_state_e;

    // Header field widths
    localparam int TLP_LEN_W = 10;
    localparam int TLP_BE_W  = 4;

endpackage

//--- logic/axi_wr_pkg.sv
package axi_wr_pkg;

    // Write response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Default burst geometry
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_LEN_W  = 4;

endpackage
